//--- Makefile
# Verilator flow for the BCH(15,7) decoder

VERILATOR  = verilator
TOP        = bch_decoder_tb
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
PASS_MSG   = TESTBENCH PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- source/bch_chien.sv
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage, Chien search by trial flip
// After k steps ch1 = S1*alpha^k and ch3 = S3*alpha^3k. XOR with one then
// adds the contribution of position N-k, scaled, which keeps the S3 = S1^3
// relation intact. A bit is in error when the trial flip lowers the count.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bch_chien (
	input  logic         clk,
	input  logic         rst,
	input  logic         syn_done,      // Load strobe for a new search
	input  gf_pkg::syn_u syn,
	output logic         err            // Current position needs a flip
);
	import gf_pkg::*;
	import bch_pkg::*;

	gf_elem_t   ch1;                    // Scaled S1 search register
	gf_elem_t   ch3;                    // Scaled S3 search register
	gf_elem_t   ch1_flip;               // Trial-flipped values
	gf_elem_t   ch3_flip;
	gf_elem_t   ch1_cube;
	logic       first;                  // Step 0, baseline count only
	err_count_e err_cnt;                // Count after the trial flip
	err_count_e err_last;               // Count to beat

	// No trial on step 0, that cycle measures the word as received
	assign ch1_flip = first ? ch1 : (ch1 ^ GF_ONE);
	assign ch3_flip = first ? ch3 : (ch3 ^ GF_ONE);

	assign ch1_cube = gf_cube(ch1_flip);

	// Error count of the trial word
	always_comb begin
		if (ch1_flip != '0) begin
			if (ch3_flip == ch1_cube) begin
				err_cnt = err_one;
			end else begin
				err_cnt = err_two;
			end
		end else begin
			if (ch3_flip != '0) begin
				err_cnt = err_many;         // Not correctable
			end else begin
				err_cnt = err_none;
			end
		end
	end

	// Flip helps only if the count dropped
	assign err = !first && (err_cnt < err_last);

	always_ff @(posedge clk) begin
		if (rst) begin
			first <= 1'b0;
		end else begin
			first <= syn_done;              // Step 0 follows the load
		end
	end

	// Search registers, absorb each flip that is kept
	always_ff @(posedge clk) begin
		if (rst) begin
			ch1 <= '0;
			ch3 <= '0;
		end else if (syn_done) begin
			ch1 <= syn.pair.s1;
			ch3 <= syn.pair.s3;
		end else begin
			ch1 <= gf_mul_alpha(err ? ch1_flip : ch1);
			ch3 <= gf_mul_alpha3(err ? ch3_flip : ch3);
		end
	end

	// Remembered count, baseline then after each correction
	always_ff @(posedge clk) begin
		if (rst) begin
			err_last <= err_none;
		end else if (first || err) begin
			err_last <= err_cnt;
		end
	end

endmodule

//--- source/bch_correct.sv
`timescale 1ns/1ps
`include "bch_defs.svh"

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result stage
// Raw bits wait N+2 cycles so the top bit of a word meets the first err.
// The window opens two cycles after syn_done and lasts K cycles, and
// output_valid and data_out are registered from it one cycle later.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bch_correct (
	input  logic clk,
	input  logic rst,
	input  logic syn_done,              // Search starts next cycle
	input  logic data_in,               // Raw stream, same as the decoder input
	input  logic err,                   // Flip for the bit at the line tail
	output logic output_valid,
	output logic data_out
);
	import bch_pkg::*;

	logic [`BCH_N+1:0] dly;             // Raw bit delay line
	logic              chien_ready;     // Step 0 of the search
	logic              window;          // err lines up with message bits
	win_cnt_t          win_cnt;         // Bits left in the window

	// Tail bit is data_in from N+2 cycles back
	always_ff @(posedge clk) begin
		dly <= {dly[`BCH_N:0], data_in};
	end

	// Window control
	always_ff @(posedge clk) begin
		if (rst) begin
			chien_ready <= 1'b0;
			window      <= 1'b0;
			win_cnt     <= '0;
		end else begin
			chien_ready <= syn_done;
			if (chien_ready) begin
				window  <= 1'b1;            // Also restarts an open window
				win_cnt <= win_cnt_t'(`BCH_K - 1);
			end else if (window) begin
				if (win_cnt == '0) begin
					window <= 1'b0;         // K bits done
				end else begin
					win_cnt <= win_cnt - win_cnt_t'(1);
				end
			end
		end
	end

	// Corrected output, zero outside the window
	always_ff @(posedge clk) begin
		if (rst) begin
			output_valid <= 1'b0;
			data_out     <= 1'b0;
		end else begin
			output_valid <= window;
			data_out     <= window & (dly[`BCH_N+1] ^ err);
		end
	end

endmodule

//--- source/bch_decoder.sv
`timescale 1ns/1ps

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BCH(15,7) double-error decoder, bit serial
// One bit per cycle in from start, message out N+3 cycles after start for
// K cycles. A new word may start right after the last bit of the previous.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bch_decoder (
	input  logic clk,
	input  logic rst,
	input  logic start,                 // Pulse with the first bit
	input  logic data_in,               // Highest degree bit first
	output logic output_valid,          // High for the K message bits
	output logic data_out               // Corrected message bit
);
	import gf_pkg::*;

	syn_u syn;                          // S3/S1 of the last finished word
	logic syn_done;
	logic err;

	// Syndromes, done N cycles after start
	bch_syndrome u_syndrome (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.data_in  (data_in),
		.syn      (syn),
		.syn_done (syn_done)
	);

	// Error positions, first err two cycles after syn_done
	bch_chien u_chien (
		.clk      (clk),
		.rst      (rst),
		.syn_done (syn_done),
		.syn      (syn),
		.err      (err)
	);

	// Delay line and correction
	bch_correct u_correct (
		.clk          (clk),
		.rst          (rst),
		.syn_done     (syn_done),
		.data_in      (data_in),
		.err          (err),
		.output_valid (output_valid),
		.data_out     (data_out)
	);

endmodule

//--- source/bch_defs.svh
`ifndef BCH_DEFS_SVH
`define BCH_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BCH(15,7) code dimensions over GF(2^4)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define BCH_M 4        // Bits per field element
`define BCH_N 15       // Codeword length, 2^M - 1
`define BCH_K 7        // Message bits, top of the codeword
`define BCH_T 2        // Correctable errors, double-error decoder

// Syndrome evaluation points are alpha^1 and alpha^3
`define BCH_S1_POW 1   // S1 = r(alpha)
`define BCH_S3_POW 3   // S3 = r(alpha^3)

`endif

//--- source/bch_pkg.sv
`include "bch_defs.svh"

package bch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Decoder types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Error count from the syndrome pair, ordered so a drop means progress
	//   none : S1 = 0,  S3 = 0
	//   one  : S1 != 0, S3 = S1^3
	//   two  : S1 != 0, S3 != S1^3
	//   many : S1 = 0,  S3 != 0
	typedef enum logic [1:0] {
		err_none = 2'd0,               // Clean word
		err_one  = 2'd1,               // Single error left
		err_two  = 2'd2,               // Two errors left
		err_many = 2'd3                // Beyond the code's reach
	} err_count_e;

	// Input bit position within a codeword, 0 to N-1
	typedef logic [$clog2(`BCH_N)-1:0] bit_cnt_t;

	// Output bits remaining in the window, K-1 down to 0
	typedef logic [$clog2(`BCH_K)-1:0] win_cnt_t;

endpackage

//--- source/bch_syndrome.sv
`timescale 1ns/1ps
`include "bch_defs.svh"

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage
// Horner evaluation of r(x) at alpha and alpha^3, highest degree bit first.
// syn_done pulses N cycles after start, with syn held until the next word.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bch_syndrome (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,         // First bit of a word on data_in
	input  logic         data_in,
	output gf_pkg::syn_u syn,           // Completed S3/S1
	output logic         syn_done       // One cycle, syn fresh
);
	import gf_pkg::*;
	import bch_pkg::*;

	gf_elem_t acc1;                     // Running S1
	gf_elem_t acc3;                     // Running S3
	gf_elem_t next1;
	gf_elem_t next3;
	gf_elem_t bit_elem;                 // Input bit as a field element
	bit_cnt_t bit_cnt;                  // Index of the bit now on data_in
	logic     busy;                     // Inside a word

	assign bit_elem = data_in ? GF_ONE : '0;

	// start drops the old accumulator so the word begins from its first bit
	assign next1 = (start ? '0 : gf_mul_alpha(acc1)) ^ bit_elem;
	assign next3 = (start ? '0 : gf_mul_alpha3(acc3)) ^ bit_elem;

	// Accumulators, reloaded by start
	always_ff @(posedge clk) begin
		acc1 <= next1;
		acc3 <= next3;
	end

	// Bit counter and result latch
	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;               // Word in flight is dropped
			bit_cnt  <= '0;
			syn_done <= 1'b0;
		end else begin
			syn_done <= 1'b0;
			if (start) begin
				busy    <= 1'b1;
				bit_cnt <= bit_cnt_t'(1);   // Bit 0 taken this cycle
			end else if (busy) begin
				if (bit_cnt == bit_cnt_t'(`BCH_N - 1)) begin
					busy     <= 1'b0;       // Last bit, word complete
					syn_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + bit_cnt_t'(1);
				end
			end
		end
	end

	// Result register, frees the accumulators for the next word
	always_ff @(posedge clk) begin
		if (busy && !start && bit_cnt == bit_cnt_t'(`BCH_N - 1)) begin
			syn.pair.s1 <= next1;           // Includes the last bit
			syn.pair.s3 <= next3;
		end
	end

endmodule

//--- source/gf_pkg.sv
`include "bch_defs.svh"

package gf_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [`BCH_M-1:0] gf_elem_t;  // Polynomial basis, bit i is x^i

	// Syndrome word, seen whole or as the S3/S1 pair
	typedef union packed {
		logic [2*`BCH_M-1:0] flat;         // Whole word, zero means clean codeword
		struct packed {
			gf_elem_t s3;                  // Upper element
			gf_elem_t s1;                  // Lower element
		} pair;
	} syn_u;

	localparam logic [`BCH_M:0] GF_POLY = 5'b10011;  // x^4 + x + 1
	localparam gf_elem_t GF_ONE = gf_elem_t'(1);      // Unit element

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Arithmetic
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One LFSR step, multiply by x and reduce
	function automatic gf_elem_t gf_xtime(input gf_elem_t a);
		return {a[`BCH_M-2:0], 1'b0} ^ (a[`BCH_M-1] ? GF_POLY[`BCH_M-1:0] : '0);
	endfunction

	// Shift-and-add product, MSB of b first
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t r;
		r = '0;
		for (int i = `BCH_M - 1; i >= 0; i--) begin
			r = gf_xtime(r) ^ (b[i] ? a : '0);
		end
		return r;
	endfunction

	function automatic gf_elem_t gf_mul_alpha(input gf_elem_t a);
		gf_elem_t r;
		r = a;
		for (int i = 0; i < `BCH_S1_POW; i++) begin
			r = gf_xtime(r);                   // One step per power of alpha
		end
		return r;
	endfunction

	function automatic gf_elem_t gf_mul_alpha3(input gf_elem_t a);
		gf_elem_t r;
		r = a;
		for (int i = 0; i < `BCH_S3_POW; i++) begin
			r = gf_xtime(r);
		end
		return r;
	endfunction

	// a^3, compared against S3 in the error count
	function automatic gf_elem_t gf_cube(input gf_elem_t a);
		gf_elem_t r;
		r = a;
		for (int i = 1; i < `BCH_S3_POW; i++) begin
			r = gf_mul(r, a);
		end
		return r;
	endfunction

endpackage

//--- sources.f
+incdir+source
source/gf_pkg.sv
source/bch_pkg.sv
source/bch_syndrome.sv
source/bch_chien.sv
source/bch_correct.sv
source/bch_decoder.sv
tb/bch_decoder_sva.sv
tb/bch_decoder_tb.sv

//--- tb/bch_decoder_sva.sv
`timescale 1ns/1ps
`include "bch_defs.svh"

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol checks on the decoder top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bch_decoder_sva (
	input logic         clk,
	input logic         rst,
	input logic         output_valid,
	input logic         data_out,
	input gf_pkg::syn_u syn,            // Latched syndromes
	input logic         syn_done,
	input logic         err
);
	import bch_pkg::*;

	bit_cnt_t valid_run;                // High cycles of output_valid so far
	bit_cnt_t clean_left;               // Window steps that must show no err

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_run <= '0;
		end else if (output_valid) begin
			if (valid_run != '1) begin
				valid_run <= valid_run + bit_cnt_t'(1);  // Saturates
			end
		end else begin
			valid_run <= '0;
		end
	end

	// Baseline step plus the K message steps
	always_ff @(posedge clk) begin
		if (rst) begin
			clean_left <= '0;
		end else if (syn_done) begin
			clean_left <= (syn.flat == '0) ? bit_cnt_t'(`BCH_K + 1) : '0;
		end else if (clean_left != '0) begin
			clean_left <= clean_left - bit_cnt_t'(1);
		end
	end

	a_data_out_idle : assert property (@(posedge clk) disable iff (rst)
		!output_valid |-> !data_out)
		else $error("data_out high while output_valid is low");

	a_valid_max : assert property (@(posedge clk) disable iff (rst)
		output_valid |-> valid_run < bit_cnt_t'(`BCH_K))
		else $error("output_valid high for more than K cycles");

	a_valid_len : assert property (@(posedge clk) disable iff (rst)
		(!output_valid && valid_run != '0) |-> valid_run == bit_cnt_t'(`BCH_K))
		else $error("output_valid window shorter than K cycles");

	a_clean_no_err : assert property (@(posedge clk) disable iff (rst)
		(clean_left != '0) |-> !err)
		else $error("err raised for a word with zero syndromes");

endmodule

bind bch_decoder bch_decoder_sva u_sva (
	.clk          (clk),
	.rst          (rst),
	.output_valid (output_valid),
	.data_out     (data_out),
	.syn          (syn),
	.syn_done     (syn_done),
	.err          (err)
);

//--- tb/bch_decoder_tb.sv
`timescale 1ns/1ps
`include "bch_defs.svh"

module bch_decoder_tb;

	typedef logic [`BCH_N-1:0] word_t;
	typedef logic [`BCH_K-1:0] msg_t;

	localparam int LATENCY   = `BCH_N + 3;      // Start cycle to output_valid
	localparam int NUM_WORDS = 45;              // Words sent over all tests
	localparam int WATCHDOG_CYCLES = NUM_WORDS * 40 + 200;
	localparam int COLLECT_LIMIT   = 40;        // Cycles to wait for a window
	localparam word_t GEN_POLY = word_t'(9'h1D1);  // x^8+x^7+x^6+x^4+1
	localparam int PAIR_A [4] = '{14, 8, 14, 3};   // Fixed double errors
	localparam int PAIR_B [4] = '{13, 7, 0, 1};

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic data_in;
	logic output_valid;
	logic data_out;

	int seed = 26849;
	int cyc = 0;                                // Free running cycle count
	int checks = 0;
	int errors = 0;
	int start_stamps [$];                       // Cycles where start was seen

	bch_decoder u_bch_decoder (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.data_in      (data_in),
		.output_valid (output_valid),
		.data_out     (data_out)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// Start monitor that forgets every word in flight on reset
	always @(negedge clk) begin
		if (rst) begin
			start_stamps.delete();
		end else if (start) begin
			start_stamps.push_back(cyc);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Encoder model and stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Systematic encoder with parity from msg*x^8 mod the generator
	function automatic word_t encode(input msg_t msg);
		word_t rem;
		rem = {msg, {(`BCH_N - `BCH_K){1'b0}}};
		for (int i = `BCH_N - 1; i >= `BCH_N - `BCH_K; i--) begin
			if (rem[i]) begin
				rem = rem ^ (GEN_POLY << (i - (`BCH_N - `BCH_K)));
			end
		end
		return {msg, rem[`BCH_N-`BCH_K-1:0]};
	endfunction

	function automatic int rand_pos();
		return ($random(seed) & 32'h7fff_ffff) % `BCH_N;
	endfunction

	// Flips up to two distinct random bits
	task automatic add_errors(input int count, inout word_t cw);
		int p1;
		int p2;
		p1 = rand_pos();
		p2 = p1;
		if (count > 0) begin
			cw = cw ^ (word_t'(1) << p1);
		end
		if (count > 1) begin
			while (p2 == p1) begin
				p2 = rand_pos();
			end
			cw = cw ^ (word_t'(1) << p2);
		end
	endtask

	task automatic send_word(input word_t cw);
		for (int i = `BCH_N - 1; i >= 0; i--) begin
			@(posedge clk);
			start   <= (i == `BCH_N - 1);        // Pulse with the top bit
			data_in <= cw[i];
		end
	endtask

	task automatic idle_bus(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			start   <= 1'b0;
			data_in <= 1'b0;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Response checking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			$display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// One output window sampled on the falling edge
	task automatic collect_word(input msg_t msg);
		int wait_cnt;
		int stamp;
		msg_t got;
		wait_cnt = 0;
		got = '0;
		@(negedge clk);
		while (!output_valid && wait_cnt < COLLECT_LIMIT) begin
			@(negedge clk);
			wait_cnt++;
		end
		if (!output_valid) begin
			$display("Output window did not open within %0d cycles at %0t",
				COLLECT_LIMIT, $time);
			errors++;
		end else begin
			if (start_stamps.size() == 0) begin
				$display("Output window at %0t has no matching start", $time);
				errors++;
			end else begin
				stamp = start_stamps.pop_front();
				check_value("output_valid latency", LATENCY, cyc - stamp);
			end
			for (int i = 0; i < `BCH_K; i++) begin
				if (i > 0) begin
					@(negedge clk);
					check_value("output_valid", 1, int'(output_valid));
				end
				got = {got[`BCH_K-2:0], data_out};  // Top message bit first
			end
			@(negedge clk);
			check_value("output_valid", 0, int'(output_valid));  // Window closed
			check_value("data_out", int'(msg), int'(got));
		end
	endtask

	task automatic decode_one(input msg_t msg, input word_t cw);
		fork
			begin
				send_word(cw);
				idle_bus(1);
			end
			collect_word(msg);
		join
	endtask

	task automatic report_test(input string name, input int words, input int err_start);
		$display("%s: %0d words, %0d errors", name, words, errors - err_start);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic clean_words();
		int err_start;
		msg_t msg;
		err_start = errors;
		for (int i = 0; i < 8; i++) begin
			msg = msg_t'($random(seed));
			decode_one(msg, encode(msg));
		end
		report_test("clean words", 8, err_start);
	endtask

	task automatic single_errors();
		int err_start;
		msg_t msg;
		err_start = errors;
		for (int p = 0; p < `BCH_N; p++) begin
			msg = msg_t'($random(seed));
			decode_one(msg, encode(msg) ^ (word_t'(1) << p));  // Parity positions too
		end
		report_test("single errors", `BCH_N, err_start);
	endtask

	task automatic double_errors();
		int err_start;
		msg_t msg;
		word_t cw;
		err_start = errors;
		for (int i = 0; i < 12; i++) begin
			msg = msg_t'($random(seed));
			cw = encode(msg);
			if (i < 4) begin
				cw = cw ^ (word_t'(1) << PAIR_A[i]) ^ (word_t'(1) << PAIR_B[i]);
			end else begin
				add_errors(2, cw);
			end
			decode_one(msg, cw);
		end
		report_test("double errors", 12, err_start);
	endtask

	task automatic back_to_back();
		int err_start;
		msg_t msgs [8];
		word_t cws [8];
		err_start = errors;
		for (int i = 0; i < 8; i++) begin
			msgs[i] = msg_t'($random(seed));
			cws[i] = encode(msgs[i]);
			add_errors(i % 3, cws[i]);           // Mix of 0, 1 and 2 errors
		end
		fork
			begin
				for (int i = 0; i < 8; i++) begin
					send_word(cws[i]);           // Next start right after last bit
				end
				idle_bus(1);
			end
			begin
				for (int i = 0; i < 8; i++) begin
					collect_word(msgs[i]);
				end
			end
		join
		report_test("back to back", 8, err_start);
	endtask

	task automatic reset_mid_word();
		int err_start;
		msg_t msg;
		word_t cw;
		err_start = errors;
		msg = msg_t'($random(seed));
		cw = encode(msg);
		for (int i = `BCH_N - 1; i >= 9; i--) begin
			@(posedge clk);
			start   <= (i == `BCH_N - 1);
			data_in <= cw[i];
		end
		@(posedge clk);
		rst     <= 1'b1;                     // Mid-word
		start   <= 1'b0;
		data_in <= 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		repeat (`BCH_N + 10) begin           // Past where the dropped word would show
			@(negedge clk);
			check_value("output_valid", 0, int'(output_valid));
			check_value("data_out", 0, int'(data_out));
		end
		msg = msg_t'($random(seed));
		cw = encode(msg);
		add_errors(2, cw);
		decode_one(msg, cw);
		report_test("reset", 2, err_start);
	endtask

	initial begin
		rst     = 1'b1;
		start   = 1'b0;
		data_in = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		idle_bus(2);
		clean_words();
		single_errors();
		double_errors();
		back_to_back();
		reset_mid_word();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
